// ==== source/rv_exec_pkg.sv ====
// RV32I execute stage shared codes
// Opcodes, function codes, ALU selects and instruction formats
package rv_exec_pkg;

  // Major opcodes
  parameter logic [6:0] OPC_OP     = 7'b0110011;
  parameter logic [6:0] OPC_OP_IMM = 7'b0010011;
  parameter logic [6:0] OPC_LOAD   = 7'b0000011;
  parameter logic [6:0] OPC_STORE  = 7'b0100011;
  parameter logic [6:0] OPC_BRANCH = 7'b1100011;
  parameter logic [6:0] OPC_LUI    = 7'b0110111;
  parameter logic [6:0] OPC_AUIPC  = 7'b0010111;

  // ALU funct3
  parameter logic [2:0] FNC_ADD_SUB = 3'b000;
  parameter logic [2:0] FNC_SLL     = 3'b001;
  parameter logic [2:0] FNC_SLT     = 3'b010;
  parameter logic [2:0] FNC_SLTU    = 3'b011;
  parameter logic [2:0] FNC_XOR     = 3'b100;
  parameter logic [2:0] FNC_SRL_SRA = 3'b101;
  parameter logic [2:0] FNC_OR      = 3'b110;
  parameter logic [2:0] FNC_AND     = 3'b111;

  // Branch funct3
  parameter logic [2:0] FNC_BEQ  = 3'b000;
  parameter logic [2:0] FNC_BNE  = 3'b001;
  parameter logic [2:0] FNC_BLT  = 3'b100;
  parameter logic [2:0] FNC_BGE  = 3'b101;
  parameter logic [2:0] FNC_BLTU = 3'b110;
  parameter logic [2:0] FNC_BGEU = 3'b111;

  typedef enum logic [1:0] {MEM_ADD, BRANCH, R_TYPE, I_TYPE} alu_op_e;

  typedef enum logic [3:0] {
    ALU_CTRL_ADD, ALU_CTRL_SUB, ALU_CTRL_AND, ALU_CTRL_OR, ALU_CTRL_XOR,
    ALU_CTRL_SLT, ALU_CTRL_SLTU, ALU_CTRL_SLL, ALU_CTRL_SRL, ALU_CTRL_SRA
  } alu_ctrl_e;

  typedef enum logic [1:0] {OUT_ADD_SUB, OUT_BITWISE, OUT_LESS, OUT_SHIFT} out_sel_e;
  typedef enum logic [1:0] {BW_NONE, BW_AND, BW_OR, BW_XOR} bitwise_sel_e;
  typedef enum logic [1:0] {SH_NONE, SH_SLL, SH_SRL, SH_SRA} shift_sel_e;
  typedef enum logic [1:0] {A_RS1, A_PC, A_ZERO} a_sel_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2, rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2, rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  // U immediate is everything above bit 11
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2, rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } bu_fmt_t;

  typedef union packed {
    r_fmt_t  r;
    i_fmt_t  i;
    s_fmt_t  s;
    bu_fmt_t bu;
  } inst_u;

endpackage

// ==== source/inst_decode.sv ====
// Instruction decoder
`timescale 1ns/1ps

module inst_decode #(
  parameter int DWIDTH = 32
) (
  input  rv_exec_pkg::inst_u   instr,
  output rv_exec_pkg::alu_op_e alu_op,
  output logic [3:0]           func,
  output rv_exec_pkg::a_sel_e  a_sel,
  output logic                 b_imm,
  output logic [DWIDTH-1:0]    imm,
  output logic                 is_branch,
  output logic                 illegal
);

  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm32;

  assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
  assign imm_s = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
  assign imm_b = {{19{instr.bu.imm_12}}, instr.bu.imm_12, instr.bu.imm_11,
                  instr.bu.imm_10_5, instr.bu.imm_4_1, 1'b0};
  assign imm_u = {instr.bu.imm_12, instr.bu.imm_10_5, instr.bu.rs2, instr.bu.rs1,
                  instr.bu.funct3, 12'b0};

  // Bit 30 picks SUB and SRA
  assign func = {instr.r.funct7[5], instr.r.funct3};

  always_comb begin
    alu_op    = rv_exec_pkg::MEM_ADD;
    a_sel     = rv_exec_pkg::A_RS1;
    b_imm     = 1'b1;
    imm32     = imm_i;
    is_branch = 1'b0;
    illegal   = 1'b0;
    case (instr.r.opcode)
      rv_exec_pkg::OPC_OP: begin
        alu_op = rv_exec_pkg::R_TYPE;
        b_imm  = 1'b0;
      end
      rv_exec_pkg::OPC_OP_IMM: alu_op = rv_exec_pkg::I_TYPE;
      rv_exec_pkg::OPC_LOAD:   imm32 = imm_i;
      rv_exec_pkg::OPC_STORE:  imm32 = imm_s;
      rv_exec_pkg::OPC_BRANCH: begin
        alu_op    = rv_exec_pkg::BRANCH;
        b_imm     = 1'b0;  // Compare rs1 against rs2
        imm32     = imm_b;
        is_branch = 1'b1;
      end
      rv_exec_pkg::OPC_LUI: begin
        a_sel = rv_exec_pkg::A_ZERO;
        imm32 = imm_u;
      end
      rv_exec_pkg::OPC_AUIPC: begin
        a_sel = rv_exec_pkg::A_PC;
        imm32 = imm_u;
      end
      default: illegal = 1'b1;
    endcase
  end

  // Sign extend to the datapath width
  assign imm = DWIDTH'($signed(imm32));

endmodule

// ==== source/alu_ctrl.sv ====
// ALU control decode
`timescale 1ns/1ps

module alu_ctrl (
  input  rv_exec_pkg::alu_op_e      alu_op,
  input  logic [3:0]                func,
  output rv_exec_pkg::out_sel_e     out_sel,
  output rv_exec_pkg::bitwise_sel_e bitwise_sel,
  output rv_exec_pkg::shift_sel_e   shift_sel,
  output logic                      sub_less,
  output logic                      slt_unsigned
);

  rv_exec_pkg::alu_ctrl_e op;

  always_comb begin
    op = rv_exec_pkg::ALU_CTRL_ADD;
    case (alu_op)
      rv_exec_pkg::MEM_ADD: op = rv_exec_pkg::ALU_CTRL_ADD;
      rv_exec_pkg::BRANCH: begin
        case (func[2:0])
          rv_exec_pkg::FNC_BLT, rv_exec_pkg::FNC_BGE:   op = rv_exec_pkg::ALU_CTRL_SLT;
          rv_exec_pkg::FNC_BLTU, rv_exec_pkg::FNC_BGEU: op = rv_exec_pkg::ALU_CTRL_SLTU;
          default: op = rv_exec_pkg::ALU_CTRL_SUB;  // BEQ, BNE
        endcase
      end
      rv_exec_pkg::R_TYPE: begin
        case (func)
          {1'b0, rv_exec_pkg::FNC_ADD_SUB}: op = rv_exec_pkg::ALU_CTRL_ADD;
          {1'b1, rv_exec_pkg::FNC_ADD_SUB}: op = rv_exec_pkg::ALU_CTRL_SUB;
          {1'b0, rv_exec_pkg::FNC_AND}:     op = rv_exec_pkg::ALU_CTRL_AND;
          {1'b0, rv_exec_pkg::FNC_OR}:      op = rv_exec_pkg::ALU_CTRL_OR;
          {1'b0, rv_exec_pkg::FNC_XOR}:     op = rv_exec_pkg::ALU_CTRL_XOR;
          {1'b0, rv_exec_pkg::FNC_SLL}:     op = rv_exec_pkg::ALU_CTRL_SLL;
          {1'b0, rv_exec_pkg::FNC_SLT}:     op = rv_exec_pkg::ALU_CTRL_SLT;
          {1'b0, rv_exec_pkg::FNC_SLTU}:    op = rv_exec_pkg::ALU_CTRL_SLTU;
          {1'b0, rv_exec_pkg::FNC_SRL_SRA}: op = rv_exec_pkg::ALU_CTRL_SRL;
          {1'b1, rv_exec_pkg::FNC_SRL_SRA}: op = rv_exec_pkg::ALU_CTRL_SRA;
          default: op = rv_exec_pkg::ALU_CTRL_ADD;
        endcase
      end
      rv_exec_pkg::I_TYPE: begin
        case (func[2:0])
          rv_exec_pkg::FNC_ADD_SUB: op = rv_exec_pkg::ALU_CTRL_ADD;  // No SUBI
          rv_exec_pkg::FNC_SLT:     op = rv_exec_pkg::ALU_CTRL_SLT;
          rv_exec_pkg::FNC_SLTU:    op = rv_exec_pkg::ALU_CTRL_SLTU;
          rv_exec_pkg::FNC_XOR:     op = rv_exec_pkg::ALU_CTRL_XOR;
          rv_exec_pkg::FNC_OR:      op = rv_exec_pkg::ALU_CTRL_OR;
          rv_exec_pkg::FNC_AND:     op = rv_exec_pkg::ALU_CTRL_AND;
          rv_exec_pkg::FNC_SLL:     op = rv_exec_pkg::ALU_CTRL_SLL;
          default: op = func[3] ? rv_exec_pkg::ALU_CTRL_SRA : rv_exec_pkg::ALU_CTRL_SRL;
        endcase
      end
      default: op = rv_exec_pkg::ALU_CTRL_ADD;
    endcase
  end

  // Fan out to the datapath selects
  always_comb begin
    out_sel      = rv_exec_pkg::OUT_ADD_SUB;
    bitwise_sel  = rv_exec_pkg::BW_NONE;
    shift_sel    = rv_exec_pkg::SH_NONE;
    sub_less     = 1'b0;
    slt_unsigned = 1'b0;
    case (op)
      rv_exec_pkg::ALU_CTRL_ADD: out_sel = rv_exec_pkg::OUT_ADD_SUB;
      rv_exec_pkg::ALU_CTRL_SUB: sub_less = 1'b1;
      rv_exec_pkg::ALU_CTRL_AND: begin
        out_sel     = rv_exec_pkg::OUT_BITWISE;
        bitwise_sel = rv_exec_pkg::BW_AND;
      end
      rv_exec_pkg::ALU_CTRL_OR: begin
        out_sel     = rv_exec_pkg::OUT_BITWISE;
        bitwise_sel = rv_exec_pkg::BW_OR;
      end
      rv_exec_pkg::ALU_CTRL_XOR: begin
        out_sel     = rv_exec_pkg::OUT_BITWISE;
        bitwise_sel = rv_exec_pkg::BW_XOR;
      end
      rv_exec_pkg::ALU_CTRL_SLT: begin
        out_sel  = rv_exec_pkg::OUT_LESS;
        sub_less = 1'b1;
      end
      rv_exec_pkg::ALU_CTRL_SLTU: begin
        out_sel      = rv_exec_pkg::OUT_LESS;
        sub_less     = 1'b1;
        slt_unsigned = 1'b1;
      end
      rv_exec_pkg::ALU_CTRL_SLL: begin
        out_sel   = rv_exec_pkg::OUT_SHIFT;
        shift_sel = rv_exec_pkg::SH_SLL;
      end
      rv_exec_pkg::ALU_CTRL_SRL: begin
        out_sel   = rv_exec_pkg::OUT_SHIFT;
        shift_sel = rv_exec_pkg::SH_SRL;
      end
      rv_exec_pkg::ALU_CTRL_SRA: begin
        out_sel   = rv_exec_pkg::OUT_SHIFT;
        shift_sel = rv_exec_pkg::SH_SRA;
      end
      default: out_sel = rv_exec_pkg::OUT_ADD_SUB;
    endcase
  end

endmodule

// ==== source/alu.sv ====
// Integer ALU
`timescale 1ns/1ps

module alu #(
  parameter int DWIDTH = 32
) (
  input  logic [DWIDTH-1:0]         a,
  input  logic [DWIDTH-1:0]         b,
  input  rv_exec_pkg::out_sel_e     out_sel,
  input  rv_exec_pkg::bitwise_sel_e bitwise_sel,
  input  rv_exec_pkg::shift_sel_e   shift_sel,
  input  logic                      sub_less,
  input  logic                      slt_unsigned,
  output logic [DWIDTH-1:0]         out
);

  localparam int SHW = $clog2(DWIDTH);

  logic [DWIDTH-1:0] add_sub_out;
  logic [DWIDTH-1:0] bitwise_out;
  logic [DWIDTH-1:0] shift_out;
  logic [SHW-1:0]    shamt;
  logic              less;

  // Two's complement subtract through inverted b plus carry in
  assign add_sub_out = a + (b ^ {DWIDTH{sub_less}}) + DWIDTH'(sub_less);

  // Differing signs decide without the difference
  assign less = (a[DWIDTH-1] == b[DWIDTH-1]) ? add_sub_out[DWIDTH-1] :
                slt_unsigned ? b[DWIDTH-1] : a[DWIDTH-1];

  always_comb begin
    case (bitwise_sel)
      rv_exec_pkg::BW_AND: bitwise_out = a & b;
      rv_exec_pkg::BW_OR:  bitwise_out = a | b;
      rv_exec_pkg::BW_XOR: bitwise_out = a ^ b;
      default:             bitwise_out = '0;
    endcase
  end

  assign shamt = b[SHW-1:0];

  always_comb begin
    case (shift_sel)
      rv_exec_pkg::SH_SLL: shift_out = a << shamt;
      rv_exec_pkg::SH_SRL: shift_out = a >> shamt;
      rv_exec_pkg::SH_SRA: shift_out = $signed(a) >>> shamt;
      default:             shift_out = '0;
    endcase
  end

  always_comb begin
    case (out_sel)
      rv_exec_pkg::OUT_ADD_SUB: out = add_sub_out;
      rv_exec_pkg::OUT_BITWISE: out = bitwise_out;
      rv_exec_pkg::OUT_LESS:    out = DWIDTH'(less);
      default:                  out = shift_out;
    endcase
  end

endmodule

// ==== source/branch_resolve.sv ====
// Branch condition and target
`timescale 1ns/1ps

module branch_resolve #(
  parameter int DWIDTH = 32
) (
  input  logic [2:0]        funct3,
  input  logic [DWIDTH-1:0] alu_out,
  input  logic [DWIDTH-1:0] pc,
  input  logic [DWIDTH-1:0] imm,
  input  logic              is_branch,
  output logic              taken,
  output logic [DWIDTH-1:0] target
);

  logic cond;
  logic zero;

  assign zero = (alu_out == '0);  // rs1 - rs2 from the ALU

  always_comb begin
    case (funct3)
      rv_exec_pkg::FNC_BEQ:  cond = zero;
      rv_exec_pkg::FNC_BNE:  cond = !zero;
      rv_exec_pkg::FNC_BLT:  cond = alu_out[0];
      rv_exec_pkg::FNC_BGE:  cond = !alu_out[0];
      rv_exec_pkg::FNC_BLTU: cond = alu_out[0];
      rv_exec_pkg::FNC_BGEU: cond = !alu_out[0];
      default:               cond = 1'b0;
    endcase
  end

  assign taken = is_branch & cond;

  // Separate adder so the ALU stays on the compare
  assign target = pc + imm;

endmodule

// ==== source/exec_unit.sv ====
// RV32I execute stage top
`timescale 1ns/1ps

module exec_unit #(
  parameter int DWIDTH = 32
) (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               in_valid,
  input  rv_exec_pkg::inst_u instr,
  input  logic [DWIDTH-1:0]  pc,
  input  logic [DWIDTH-1:0]  rs1_val,
  input  logic [DWIDTH-1:0]  rs2_val,
  output logic               out_valid,
  output logic               branch_taken,
  output logic               illegal_instr,
  output logic [DWIDTH-1:0]  result,
  output logic [DWIDTH-1:0]  branch_target
);

  rv_exec_pkg::alu_op_e      alu_op;
  rv_exec_pkg::a_sel_e       a_sel;
  rv_exec_pkg::out_sel_e     out_sel;
  rv_exec_pkg::bitwise_sel_e bitwise_sel;
  rv_exec_pkg::shift_sel_e   shift_sel;
  logic [3:0]                func;
  logic                      b_imm, is_branch, illegal;
  logic                      sub_less, slt_unsigned, taken;
  logic [DWIDTH-1:0]         imm, op_a, op_b, alu_out, target;

  inst_decode #(.DWIDTH(DWIDTH)) decode_i (
    .instr, .alu_op, .func, .a_sel, .b_imm, .imm, .is_branch, .illegal
  );

  alu_ctrl ctrl_i (
    .alu_op, .func, .out_sel, .bitwise_sel, .shift_sel, .sub_less, .slt_unsigned
  );

  // Operand muxes
  always_comb begin
    case (a_sel)
      rv_exec_pkg::A_PC:   op_a = pc;
      rv_exec_pkg::A_ZERO: op_a = '0;  // LUI
      default:             op_a = rs1_val;
    endcase
  end
  assign op_b = b_imm ? imm : rs2_val;

  alu #(.DWIDTH(DWIDTH)) alu_i (
    .a(op_a), .b(op_b), .out_sel, .bitwise_sel, .shift_sel, .sub_less, .slt_unsigned,
    .out(alu_out)
  );

  branch_resolve #(.DWIDTH(DWIDTH)) branch_i (
    .funct3(instr.r.funct3), .alu_out, .pc, .imm, .is_branch, .taken, .target
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid     <= 1'b0;
      branch_taken  <= 1'b0;
      illegal_instr <= 1'b0;
      result        <= '0;
      branch_target <= '0;
    end else begin
      out_valid <= in_valid;
      if (in_valid) begin  // Hold last values while idle
        branch_taken  <= taken;
        illegal_instr <= illegal;
        result        <= alu_out;
        branch_target <= target;
      end
    end
  end

endmodule

// ==== bench/exec_unit_tb.sv ====
// Execute stage testbench
`timescale 1ns/1ps

module exec_unit_tb;

  localparam int DWIDTH = 32;

  logic               clk, arst_n, in_valid;
  rv_exec_pkg::inst_u instr;
  logic [DWIDTH-1:0]  pc, rs1_val, rs2_val;
  logic               out_valid, branch_taken, illegal_instr;
  logic [DWIDTH-1:0]  result, branch_target;
  logic [31:0]        rng;
  int                 err_count;

  exec_unit #(.DWIDTH(DWIDTH)) dut_i (
    .clk, .arst_n, .in_valid, .instr, .pc, .rs1_val, .rs2_val,
    .out_valid, .branch_taken, .illegal_instr, .result, .branch_target
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Instruction builders, rd=3 rs1=1 rs2=2
  function automatic rv_exec_pkg::inst_u r_inst(input logic alt, input logic [2:0] f3);
    rv_exec_pkg::inst_u w;
    w.r = {1'b0, alt, 5'd0, 5'd2, 5'd1, f3, 5'd3, rv_exec_pkg::OPC_OP};
    return w;
  endfunction

  function automatic rv_exec_pkg::inst_u i_inst(input logic [11:0] imm, input logic [2:0] f3,
                                                input logic [6:0] opc);
    rv_exec_pkg::inst_u w;
    w.i = {imm, 5'd1, f3, 5'd3, opc};
    return w;
  endfunction

  function automatic rv_exec_pkg::inst_u s_inst(input logic [11:0] imm, input logic [2:0] f3);
    rv_exec_pkg::inst_u w;
    w.s = {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], rv_exec_pkg::OPC_STORE};
    return w;
  endfunction

  function automatic rv_exec_pkg::inst_u b_inst(input logic [12:0] imm, input logic [2:0] f3);
    rv_exec_pkg::inst_u w;
    w.bu = {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], rv_exec_pkg::OPC_BRANCH};
    return w;
  endfunction

  function automatic rv_exec_pkg::inst_u u_inst(input logic [19:0] imm, input logic [6:0] opc);
    rv_exec_pkg::inst_u w;
    w = {imm, 5'd3, opc};
    return w;
  endfunction

  // RV32I arithmetic by funct3, alt is instruction bit 30
  function automatic logic [31:0] alu_ref(input logic [31:0] a, b, input logic [2:0] f3,
                                          input logic alt);
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return {31'b0, $signed(a) < $signed(b)};
      3'b011: return {31'b0, a < b};
      3'b100: return a ^ b;
      3'b101: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic ref_model(input logic [31:0] ins, pc_v, a, b, output logic [31:0] res,
                           output logic tk, output logic [31:0] tgt, output logic il);
    logic [2:0]  f3;
    logic [31:0] imm_i, imm_s, imm_b, imm_u;
    f3    = ins[14:12];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_u = {ins[31:12], 12'b0};
    tk  = 1'b0;
    il  = 1'b0;
    tgt = pc_v + imm_b;
    case (ins[6:0])
      rv_exec_pkg::OPC_OP:     res = alu_ref(a, b, f3, ins[30]);
      rv_exec_pkg::OPC_OP_IMM: res = alu_ref(a, imm_i, f3, (f3 == 3'b101) & ins[30]);
      rv_exec_pkg::OPC_LOAD:   res = a + imm_i;
      rv_exec_pkg::OPC_STORE:  res = a + imm_s;
      rv_exec_pkg::OPC_LUI:    res = imm_u;
      rv_exec_pkg::OPC_AUIPC:  res = pc_v + imm_u;
      rv_exec_pkg::OPC_BRANCH: begin
        case (f3)
          rv_exec_pkg::FNC_BEQ:  tk = (a == b);
          rv_exec_pkg::FNC_BNE:  tk = (a != b);
          rv_exec_pkg::FNC_BLT:  tk = ($signed(a) < $signed(b));
          rv_exec_pkg::FNC_BGE:  tk = ($signed(a) >= $signed(b));
          rv_exec_pkg::FNC_BLTU: tk = (a < b);
          rv_exec_pkg::FNC_BGEU: tk = (a >= b);
          default:               tk = 1'b0;
        endcase
        // Compare value left on the ALU output
        res = f3[2] ? alu_ref(a, b, {2'b01, f3[1]}, 1'b0) : a - b;
      end
      default: begin
        il  = 1'b1;
        res = a + imm_i;  // Falls back to address add
      end
    endcase
  endtask

  task automatic check_word(input string name, input logic [DWIDTH-1:0] exp, act);
    if (act !== exp) begin
      $display("ERR %s expected %h got %h", name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, act);
    if (act !== exp) begin
      $display("ERR %s expected %h got %h", name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_outputs(input logic [31:0] e_res, e_tgt, input logic e_tk, e_il,
                               input logic chk_tgt);
    check_word("result", e_res, result);
    check_bit("branch_taken", e_tk, branch_taken);
    check_bit("illegal_instr", e_il, illegal_instr);
    if (chk_tgt)
      check_word("branch_target", e_tgt, branch_target);
  endtask

  // Issue one instruction, wait for out_valid and compare
  task automatic exec_one(input rv_exec_pkg::inst_u ins, input logic [31:0] pc_v, a, b);
    logic [31:0] e_res, e_tgt;
    logic        e_tk, e_il;
    int          cnt;
    ref_model(ins, pc_v, a, b, e_res, e_tk, e_tgt, e_il);
    instr    = ins;
    pc       = pc_v;
    rs1_val  = a;
    rs2_val  = b;
    in_valid = 1'b1;
    @(posedge clk);
    #2 in_valid = 1'b0;
    cnt = 0;
    while (!out_valid && cnt < 20) begin
      @(posedge clk);
      #2 cnt++;
    end
    if (!out_valid) begin
      $display("Timeout: out_valid did not rise within 20 cycles for instruction %h", ins);
      err_count++;
    end else begin
      check_outputs(e_res, e_tgt, e_tk, e_il, ins[6:0] == rv_exec_pkg::OPC_BRANCH);
    end
  endtask

  task automatic test_r_type();
    logic [31:0] ca [5];
    logic [31:0] cb [5];
    ca[0] = 32'h7fff_ffff;
    cb[0] = 32'h8000_0000;
    ca[1] = 32'h8000_0000;
    cb[1] = 32'h7fff_ffff;
    ca[2] = 32'hffff_ffff;
    cb[2] = 32'h0000_0001;
    ca[3] = 32'h8000_0001;
    cb[3] = 32'd35;  // Shift amount wraps to 3
    ca[4] = 32'hdead_beef;
    cb[4] = 32'hffff_ffe4;
    for (int k = 0; k < 16; k++) begin
      if (!k[3] || k[2:0] == 3'b000 || k[2:0] == 3'b101) begin
        for (int p = 0; p < 5; p++)
          exec_one(r_inst(k[3], k[2:0]), 32'h100, ca[p], cb[p]);
        for (int r = 0; r < 3; r++)
          exec_one(r_inst(k[3], k[2:0]), 32'h100, xorshift32(), xorshift32());
      end
    end
  endtask

  task automatic test_i_type();
    for (int k = 0; k < 8; k++) begin
      if (k != 1 && k != 5) begin
        exec_one(i_inst(12'hff0, k[2:0], rv_exec_pkg::OPC_OP_IMM), 32'h0, xorshift32(), '0);
        exec_one(i_inst(12'h800, k[2:0], rv_exec_pkg::OPC_OP_IMM), 32'h0, 32'h8000_0000, '0);
        exec_one(i_inst(12'hfff, k[2:0], rv_exec_pkg::OPC_OP_IMM), 32'h0, 32'h0000_0005, '0);
      end
    end
    exec_one(i_inst({7'h00, 5'd7}, rv_exec_pkg::FNC_SLL, rv_exec_pkg::OPC_OP_IMM),
             32'h0, 32'h80f0_1234, '0);
    exec_one(i_inst({7'h00, 5'd12}, rv_exec_pkg::FNC_SRL_SRA, rv_exec_pkg::OPC_OP_IMM),
             32'h0, 32'h8765_4321, '0);
    exec_one(i_inst({7'h20, 5'd12}, rv_exec_pkg::FNC_SRL_SRA, rv_exec_pkg::OPC_OP_IMM),
             32'h0, 32'h8765_4321, '0);
    exec_one(i_inst({7'h20, 5'd31}, rv_exec_pkg::FNC_SRL_SRA, rv_exec_pkg::OPC_OP_IMM),
             32'h0, 32'hc000_0000, '0);
  endtask

  task automatic test_mem_upper();
    exec_one(i_inst(12'hffc, 3'b010, rv_exec_pkg::OPC_LOAD), 32'h0, 32'h0000_1000, '0);
    exec_one(i_inst(12'h7ff, 3'b000, rv_exec_pkg::OPC_LOAD), 32'h0, xorshift32(), '0);
    exec_one(s_inst(12'h804, 3'b010), 32'h0, 32'h0000_2000, xorshift32());
    exec_one(s_inst(12'h01c, 3'b000), 32'h0, xorshift32(), xorshift32());
    exec_one(u_inst(20'habcde, rv_exec_pkg::OPC_LUI), 32'h0, xorshift32(), '0);
    exec_one(u_inst(20'hfffff, rv_exec_pkg::OPC_AUIPC), 32'h0000_0400, '0, '0);
    exec_one(u_inst(20'h00012, rv_exec_pkg::OPC_AUIPC), 32'h8000_fffc, '0, '0);
  endtask

  task automatic test_branch();
    logic [31:0] rnd;
    for (int k = 0; k < 8; k++) begin
      if (k != 2 && k != 3) begin
        rnd = xorshift32();
        exec_one(b_inst({rnd[12:1], 1'b0}, k[2:0]), {rnd[31:2], 2'b0}, 32'd5, 32'd5);
        exec_one(b_inst(13'h1ff8, k[2:0]), 32'h0000_2000, 32'hffff_ffff, 32'd1);
        exec_one(b_inst(13'h0010, k[2:0]), 32'h0000_2000, 32'd1, 32'hffff_ffff);
        exec_one(b_inst({rnd[24:13], 1'b0}, k[2:0]), 32'h40, xorshift32(), xorshift32());
      end
    end
  endtask

  task automatic test_stream();
    rv_exec_pkg::inst_u seq [10];
    logic [31:0] s_pc [10];
    logic [31:0] s_a [10];
    logic [31:0] s_b [10];
    logic [31:0] e_res [10];
    logic [31:0] e_tgt [10];
    logic        e_tk [10];
    logic        e_il [10];
    seq[0] = r_inst(1'b0, rv_exec_pkg::FNC_ADD_SUB);
    seq[1] = r_inst(1'b1, rv_exec_pkg::FNC_ADD_SUB);
    seq[2] = i_inst(12'hf80, rv_exec_pkg::FNC_ADD_SUB, rv_exec_pkg::OPC_OP_IMM);
    seq[3] = u_inst(20'h12345, rv_exec_pkg::OPC_LUI);
    seq[4] = b_inst(13'h1ff0, rv_exec_pkg::FNC_BNE);
    seq[5] = u_inst(20'h00010, rv_exec_pkg::OPC_AUIPC);
    seq[6] = 32'h0000_007f;  // Unknown opcode
    seq[7] = r_inst(1'b0, rv_exec_pkg::FNC_SLTU);
    seq[8] = r_inst(1'b1, rv_exec_pkg::FNC_SRL_SRA);
    seq[9] = s_inst(12'h010, 3'b010);
    for (int k = 0; k < 10; k++) begin
      s_pc[k] = xorshift32() & 32'hffff_fff0;
      s_a[k]  = xorshift32();
      s_b[k]  = xorshift32();
      ref_model(seq[k], s_pc[k], s_a[k], s_b[k], e_res[k], e_tk[k], e_tgt[k], e_il[k]);
    end
    for (int k = 0; k < 10; k++) begin
      instr    = seq[k];
      pc       = s_pc[k];
      rs1_val  = s_a[k];
      rs2_val  = s_b[k];
      in_valid = 1'b1;
      @(posedge clk);
      #2 check_bit("out_valid", 1'b1, out_valid);
      check_outputs(e_res[k], e_tgt[k], e_tk[k], e_il[k],
                    seq[k].r.opcode == rv_exec_pkg::OPC_BRANCH);
    end
    in_valid = 1'b0;
    instr    = seq[6];  // Idle inputs must not reach the outputs
    rs1_val  = ~s_a[9];
    @(posedge clk);
    #2 check_bit("out_valid", 1'b0, out_valid);
    check_outputs(e_res[9], e_tgt[9], e_tk[9], e_il[9], 1'b0);
  endtask

  initial begin
    clk       = 1'b0;
    arst_n    = 1'b0;
    in_valid  = 1'b0;
    instr     = '0;
    pc        = '0;
    rs1_val   = '0;
    rs2_val   = '0;
    rng       = 32'd66;
    err_count = 0;
    repeat (2) @(posedge clk);
    #2 arst_n = 1'b1;
    check_bit("out_valid", 1'b0, out_valid);
    check_bit("branch_taken", 1'b0, branch_taken);
    check_bit("illegal_instr", 1'b0, illegal_instr);
    check_word("result", '0, result);
    check_word("branch_target", '0, branch_target);
    test_r_type();
    test_i_type();
    test_mem_upper();
    test_branch();
    test_stream();
    $display("Errors: %0d", err_count);
    if (err_count == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

// ==== exec_unit.f ====
source/rv_exec_pkg.sv
source/inst_decode.sv
source/alu_ctrl.sv
source/alu.sv
source/branch_resolve.sv
source/exec_unit.sv
bench/exec_unit_tb.sv

// ==== Makefile ====
# Verilator build for the execute stage testbench

TOP := exec_unit_tb
SIM := obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): exec_unit.f source/*.sv bench/*.sv
	verilator --binary --top-module $(TOP) -f exec_unit.f -Mdir obj_dir

# Pass only when the log holds the pass line
run: $(SIM)
	./$(SIM) | tee run.log
	grep -q "^Test OK$$" run.log

clean:
	rm -rf obj_dir run.log
